// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  localparam word_t nop_instr = 32'h0000_0013;  // ADDI x0, x0, 0

  typedef enum logic [3:0] {
    add,
    sub,
    and_op,
    or_op,
    xor_op,
    slt,
    sltu,
    sll,
    srl,
    sra,
    pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_wb,
    fwd_mem
  } fwd_sel_e;

  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_pc4
  } result_src_e;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_jal,
    br_jalr
  } branch_e;

  // All-zero value is a NOP
  typedef struct packed {
    logic        reg_write;
    logic        mem_write;
    alu_op_e     alu_op;
    logic        alu_src_imm;
    result_src_e result_src;
    branch_e     branch;
  } ctrl_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: rv_decoder.sv
`default_nettype none

module rv_decoder
  import rv_pkg::*;
(
  input  wire word_t instr,
  output ctrl_t      ctrl,
  output word_t      imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by register and immediate forms, alt is instr[30]
  function automatic alu_op_e alu_op_of(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? sub : add;
      3'b001:  return sll;
      3'b010:  return slt;
      3'b011:  return sltu;
      3'b100:  return xor_op;
      3'b101:  return alt ? sra : srl;
      3'b110:  return or_op;
      default: return and_op;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    imm  = imm_i;
    case (opcode)
      op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_op_of(funct3, instr[30]);
      end
      op_imm: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_op_of(funct3, funct3 == 3'b101 && instr[30]);  // No SUBI
      end
      op_lui: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = pass_b;
        imm              = imm_u;
      end
      op_load: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.result_src  = res_mem;
      end
      op_store: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = imm_s;
      end
      op_branch: begin
        ctrl.alu_op = sub;
        imm         = imm_b;
        case (funct3)
          3'b000:  ctrl.branch = br_eq;
          3'b001:  ctrl.branch = br_ne;
          3'b100:  ctrl.branch = br_lt;
          3'b101:  ctrl.branch = br_ge;
          default: ctrl.branch = br_none;  // Unsigned compares unsupported
        endcase
      end
      op_jal: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_src = res_pc4;
        ctrl.branch     = br_jal;
        imm             = imm_j;
      end
      op_jalr: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.result_src  = res_pc4;
        ctrl.branch      = br_jalr;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

module rv_regfile
  import rv_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire reg_addr_t ra1,
  input  wire reg_addr_t ra2,
  output word_t          rd1,
  output word_t          rd2,
  input  wire reg_addr_t wa,
  input  wire word_t     wd,
  input  wire logic      we
);

  word_t regs [1:31];  // x0 has no storage

  function automatic word_t read_port(reg_addr_t ra);
    if (ra == '0) return '0;
    if (we && wa == ra) return wd;  // Write-through
    return regs[ra];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = read_port(ra1);
  assign rd2 = read_port(ra2);

  // A written register reads back its value one cycle later
  a_write_kept: assert property (@(posedge clk) disable iff (!rst_n)
    (we && wa != '0) |=> (ra1 != $past(wa) || (we && wa == ra1) || rd1 == $past(wd)));

endmodule

`default_nettype wire

// File: rv_alu.sv
`default_nettype none

module rv_alu
  import rv_pkg::*;
(
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_e op,
  output word_t        y,
  output logic         zero,
  output logic         lt
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      add:     y = a + b;
      sub:     y = a - b;
      and_op:  y = a & b;
      or_op:   y = a | b;
      xor_op:  y = a ^ b;
      slt:     y = {31'b0, $signed(a) < $signed(b)};
      sltu:    y = {31'b0, a < b};
      sll:     y = a << shamt;
      srl:     y = a >> shamt;
      sra:     y = $signed(a) >>> shamt;
      pass_b:  y = b;
      default: y = '0;
    endcase
  end

  // Branch flags, independent of op
  assign zero = a == b;
  assign lt   = $signed(a) < $signed(b);

endmodule

`default_nettype wire

// File: rv_hazard_unit.sv
`default_nettype none

module rv_hazard_unit
  import rv_pkg::*;
(
  input  wire reg_addr_t rs1_e,
  input  wire reg_addr_t rs2_e,
  input  wire reg_addr_t rd_m,
  input  wire reg_addr_t rd_w,
  input  wire reg_addr_t rs1_d,
  input  wire reg_addr_t rs2_d,
  input  wire reg_addr_t rd_e,
  input  wire logic      reg_write_m,
  input  wire logic      reg_write_w,
  input  wire logic      load_e,
  input  wire logic      redirect_e,
  output fwd_sel_e       fwd_a,
  output fwd_sel_e       fwd_b,
  output logic           stall,
  output logic           flush_d,
  output logic           flush_e
);

  logic load_use;

  // Memory stage wins over writeback
  function automatic fwd_sel_e fwd_of(reg_addr_t rs);
    if (rs == '0) return fwd_none;
    if (reg_write_m && rs == rd_m) return fwd_mem;
    if (reg_write_w && rs == rd_w) return fwd_wb;
    return fwd_none;
  endfunction

  assign fwd_a = fwd_of(rs1_e);
  assign fwd_b = fwd_of(rs2_e);

  assign load_use = load_e && rd_e != '0 && (rs1_d == rd_e || rs2_d == rd_e);

  assign stall   = load_use;
  assign flush_d = redirect_e;
  assign flush_e = load_use || redirect_e;

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter word_t RESET_VECTOR = 32'h0000_0000
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  output word_t      imem_addr,
  input  wire word_t imem_data,
  output dmem_req_t  dmem_req,
  input  wire word_t dmem_rdata
);

  typedef struct packed {
    word_t instr;
    word_t pc;
  } de_reg_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     rd1;
    word_t     rd2;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } ex_reg_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_y;
    word_t     wdata;
    word_t     pc4;
    reg_addr_t rd;
  } me_reg_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_y;
    word_t     rdata;
    word_t     pc4;
    reg_addr_t rd;
  } wb_reg_t;

  word_t    pc_f;
  de_reg_t  de_r;
  ex_reg_t  ex_r;
  me_reg_t  me_r;
  wb_reg_t  wb_r;
  ctrl_t    ctrl_d;
  word_t    imm_d;
  word_t    rd1_d;
  word_t    rd2_d;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  logic     stall;
  logic     flush_d;
  logic     flush_e;
  word_t    src_a_e;
  word_t    src_b_e;
  word_t    alu_y_e;
  logic     zero_e;
  logic     lt_e;
  logic     redirect_e;
  word_t    target_e;
  word_t    result_m;
  word_t    result_w;

  // Fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f <= RESET_VECTOR;
    end else if (redirect_e) begin
      pc_f <= target_e;
    end else if (!stall) begin
      pc_f <= pc_f + 32'd4;
    end
  end

  assign imem_addr = pc_f;

  // Decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_r <= '{instr: nop_instr, pc: '0};
    end else if (flush_d) begin
      de_r <= '{instr: nop_instr, pc: '0};
    end else if (!stall) begin
      de_r <= '{instr: imem_data, pc: pc_f};
    end
  end

  rv_decoder i_decoder (.instr(de_r.instr), .ctrl(ctrl_d), .imm(imm_d));

  rv_regfile i_regfile (
    .clk  (clk),
    .rst_n(rst_n),
    .ra1  (de_r.instr[19:15]),
    .ra2  (de_r.instr[24:20]),
    .rd1  (rd1_d),
    .rd2  (rd2_d),
    .wa   (wb_r.rd),
    .wd   (result_w),
    .we   (wb_r.ctrl.reg_write)
  );

  rv_hazard_unit i_hazard (
    .rs1_e      (ex_r.rs1),
    .rs2_e      (ex_r.rs2),
    .rd_m       (me_r.rd),
    .rd_w       (wb_r.rd),
    .rs1_d      (de_r.instr[19:15]),
    .rs2_d      (de_r.instr[24:20]),
    .rd_e       (ex_r.rd),
    .reg_write_m(me_r.ctrl.reg_write),
    .reg_write_w(wb_r.ctrl.reg_write),
    .load_e     (ex_r.ctrl.result_src == res_mem),
    .redirect_e (redirect_e),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .stall      (stall),
    .flush_d    (flush_d),
    .flush_e    (flush_e)
  );

  // Execute
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_r <= '0;
    end else if (flush_e) begin
      ex_r <= '0;  // Bubble
    end else begin
      ex_r <= '{ctrl: ctrl_d, pc: de_r.pc, rd1: rd1_d, rd2: rd2_d, imm: imm_d,
                rs1: de_r.instr[19:15], rs2: de_r.instr[24:20], rd: de_r.instr[11:7]};
    end
  end

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val);
    case (sel)
      fwd_mem: return result_m;
      fwd_wb:  return result_w;
      default: return reg_val;
    endcase
  endfunction

  assign src_a_e = fwd_mux(fwd_a, ex_r.rd1);
  assign src_b_e = fwd_mux(fwd_b, ex_r.rd2);

  rv_alu i_alu (
    .a   (src_a_e),
    .b   (ex_r.ctrl.alu_src_imm ? ex_r.imm : src_b_e),
    .op  (ex_r.ctrl.alu_op),
    .y   (alu_y_e),
    .zero(zero_e),
    .lt  (lt_e)
  );

  always_comb begin
    case (ex_r.ctrl.branch)
      br_eq:           redirect_e = zero_e;
      br_ne:           redirect_e = !zero_e;
      br_lt:           redirect_e = lt_e;
      br_ge:           redirect_e = !lt_e;
      br_jal, br_jalr: redirect_e = 1'b1;
      default:         redirect_e = 1'b0;
    endcase
  end

  assign target_e = ex_r.ctrl.branch == br_jalr ? {alu_y_e[31:1], 1'b0} : ex_r.pc + ex_r.imm;

  // Memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      me_r <= '0;
    end else begin
      me_r <= '{ctrl: ex_r.ctrl, alu_y: alu_y_e, wdata: src_b_e,
                pc4: ex_r.pc + 32'd4, rd: ex_r.rd};
    end
  end

  assign dmem_req = '{addr: me_r.alu_y, wdata: me_r.wdata, we: me_r.ctrl.mem_write};

  // Load data never forwards from here, the stall covers it
  assign result_m = me_r.ctrl.result_src == res_pc4 ? me_r.pc4 : me_r.alu_y;

  // Writeback
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_r <= '0;
    end else begin
      wb_r <= '{ctrl: me_r.ctrl, alu_y: me_r.alu_y, rdata: dmem_rdata,
                pc4: me_r.pc4, rd: me_r.rd};
    end
  end

  always_comb begin
    case (wb_r.ctrl.result_src)
      res_mem: result_w = wb_r.rdata;
      res_pc4: result_w = wb_r.pc4;
      default: result_w = wb_r.alu_y;
    endcase
  end

  // Bubble from execute reaches memory two edges later
  a_no_store_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
    flush_e |-> ##2 !dmem_req.we);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  input  wire logic restart,
  output logic      clk,
  output logic      rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // Period 20
  end

  // Reset drops on a falling edge and holds for three cycles
  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      do begin
        @(negedge clk);
      end while (!restart);
      rst_n = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rv_core_tb.sv
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
();

  logic      clk;
  logic      rst_n;
  logic      restart;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  word_t     prog [1024];
  word_t     dmem [256];
  word_t     init_mem [256];
  word_t     prog_q [$];
  dmem_req_t expected_q [$];
  int        actual_count;
  logic      store_done;
  int        store_errors;
  int        count_errors;
  int        timeout_errors;
  integer    seed;

  tb_clock_gen i_clock (.restart(restart), .clk(clk), .rst_n(rst_n));

  rv_core #(.RESET_VECTOR(32'h0000_0000)) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dmem_req  (dmem_req),
    .dmem_rdata(dmem_rdata)
  );

  assign imem_data  = prog[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];  // 1 KiB, wraps

  function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic word_t lui_instr(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, op_lui};
  endfunction

  task automatic emit(input word_t instr);
    prog_q.push_back(instr);
  endtask

  // Every program signs off with a store to 0xFFC and parks
  task automatic finish_program();
    emit(lui_instr(20'h00001, 31));
    emit(s_type(12'hffc, 1, 31));
    emit(j_type(21'd0, 0));
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  // ISA-level run of prog, collecting the ordered store list
  function automatic void run_reference();
    word_t      regs [32];
    word_t      mem [256];
    word_t      pc;
    word_t      next_pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      ea;
    logic [2:0] f3;
    dmem_req_t  st;
    expected_q.delete();
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = init_mem[i];
    end
    pc = '0;
    for (int step = 0; step < 10000; step++) begin
      ins     = prog[pc[11:2]];
      f3      = ins[14:12];
      a       = regs[ins[19:15]];
      b       = regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      next_pc = pc + 32'd4;
      case (ins[6:0])
        op_reg: regs[ins[11:7]] = alu_ref(f3, ins[30], a, b);
        op_imm: regs[ins[11:7]] = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
        op_lui: regs[ins[11:7]] = {ins[31:12], 12'b0};
        op_load: begin
          ea = a + imm_i;
          regs[ins[11:7]] = mem[ea[9:2]];
        end
        op_store: begin
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          mem[ea[9:2]] = b;
          st.addr  = ea;
          st.wdata = b;
          st.we    = 1'b1;
          expected_q.push_back(st);
          if (ea == 32'h0000_0ffc) return;
        end
        op_branch: begin
          if (branch_taken(f3, a, b))
            next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        op_jal: begin
          regs[ins[11:7]] = pc + 32'd4;
          next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        op_jalr: begin
          next_pc = (a + imm_i) & ~32'd1;  // Link written after target uses rs1
          regs[ins[11:7]] = pc + 32'd4;
        end
        default: ;
      endcase
      regs[0] = '0;
      pc = next_pc;
    end
  endfunction

  task automatic check_store(input dmem_req_t actual, input dmem_req_t expected);
    if (actual !== expected) begin
      store_errors++;
      $display("[FAIL] %0t store addr %h data %h we %b, expected addr %h data %h we %b",
               $time, actual.addr, actual.wdata, actual.we,
               expected.addr, expected.wdata, expected.we);
    end
  endtask

  task automatic check_count(input int actual, input int expected);
    if (actual != expected) begin
      count_errors++;
      $display("[FAIL] %0t %0d stores seen, %0d expected", $time, actual, expected);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n === 1'b0 && dmem_req.we === 1'b1) begin
      store_errors++;
      $display("Store strobe was high during reset at time %0t", $time);
    end else if (rst_n === 1'b1 && dmem_req.we !== 1'b0) begin
      if (actual_count < expected_q.size())
        check_store(dmem_req, expected_q[actual_count]);
      else
        check_store(dmem_req, '0);  // More stores than the model
      actual_count++;
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
      if (dmem_req.addr == 32'h0000_0ffc) store_done = 1'b1;
    end
  end

  task automatic run_program(input string name);
    int cycles;
    $display("Running %s", name);
    if (rst_n === 1'b1) restart = 1'b1;
    cycles = 0;
    while (rst_n !== 1'b0 && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    restart = 1'b0;
    if (rst_n !== 1'b0) begin
      timeout_errors++;
      $display("Reset never asserted before %s", name);
    end
    for (int i = 0; i < 1024; i++) begin
      prog[i] = (i < prog_q.size()) ? prog_q[i] : nop_instr;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = init_mem[i];
    end
    run_reference();
    actual_count = 0;
    store_done   = 1'b0;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    cycles = 0;
    while (!store_done && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!store_done) begin
      timeout_errors++;
      $display("Program %s did not reach its final store within 2000 cycles", name);
    end
    check_count(actual_count, expected_q.size());
    prog_q.delete();
  endtask

  task automatic alu_program();
    emit(lui_instr(20'h12345, 1));
    emit(i_type(12'h678, 1, 3'b000, 1, op_imm));
    emit(i_type(12'hffb, 0, 3'b000, 2, op_imm));  // x2 = -5
    emit(r_type(7'h00, 2, 1, 3'b000, 3));
    emit(r_type(7'h20, 1, 3, 3'b000, 4));
    emit(r_type(7'h00, 3, 4, 3'b100, 5));
    emit(r_type(7'h00, 2, 5, 3'b110, 6));
    emit(r_type(7'h00, 1, 6, 3'b111, 7));
    emit(r_type(7'h00, 1, 2, 3'b010, 8));
    emit(r_type(7'h00, 1, 2, 3'b011, 9));
    emit(r_type(7'h00, 2, 1, 3'b001, 10));
    emit(r_type(7'h00, 8, 2, 3'b101, 11));
    emit(r_type(7'h20, 8, 2, 3'b101, 12));
    emit(i_type(12'd4, 1, 3'b001, 13, op_imm));
    emit(i_type(12'h402, 2, 3'b101, 15, op_imm));
    emit(i_type(12'd28, 2, 3'b101, 16, op_imm));
    emit(i_type(12'hfff, 1, 3'b100, 17, op_imm));
    emit(i_type(12'h0f0, 2, 3'b110, 18, op_imm));
    emit(i_type(12'h0ff, 1, 3'b111, 19, op_imm));
    emit(i_type(12'hffc, 2, 3'b010, 20, op_imm));
    emit(i_type(12'd5, 2, 3'b011, 21, op_imm));
    emit(i_type(12'd7, 1, 3'b000, 0, op_imm));  // Write to x0 must vanish
    emit(r_type(7'h00, 1, 0, 3'b000, 14));
    for (int r = 1; r < 22; r++) begin
      emit(s_type(12'h100 + 4 * r, r, 0));
    end
    finish_program();
  endtask

  task automatic load_program();
    emit(i_type(12'h040, 0, 3'b000, 1, op_imm));
    emit(i_type(12'd77, 0, 3'b000, 4, op_imm));
    emit(i_type(12'd0, 1, 3'b010, 2, op_load));
    emit(r_type(7'h00, 4, 2, 3'b000, 3));  // Uses load result at once
    emit(s_type(12'h080, 3, 0));
    emit(i_type(12'd4, 1, 3'b010, 5, op_load));
    emit(s_type(12'h084, 5, 0));
    emit(s_type(12'd8, 3, 1));
    emit(i_type(12'd8, 1, 3'b010, 6, op_load));
    emit(i_type(12'd1, 6, 3'b000, 7, op_imm));
    emit(s_type(12'h088, 7, 0));
    finish_program();
  endtask

  task automatic branch_program();
    emit(i_type(12'd5, 0, 3'b000, 1, op_imm));
    emit(i_type(12'hffd, 0, 3'b000, 2, op_imm));  // x2 = -3
    emit(i_type(12'd5, 0, 3'b000, 3, op_imm));
    emit(b_type(13'd8, 3, 1, 3'b000));            // Taken
    emit(s_type(12'h100, 1, 0));
    emit(s_type(12'h104, 2, 0));
    emit(b_type(13'd8, 2, 1, 3'b000));
    emit(s_type(12'h108, 1, 0));
    emit(b_type(13'd12, 2, 1, 3'b001));           // Taken, skips two
    emit(s_type(12'h10c, 1, 0));
    emit(s_type(12'h110, 1, 0));
    emit(b_type(13'd8, 3, 1, 3'b001));
    emit(s_type(12'h114, 3, 0));
    emit(b_type(13'd8, 1, 2, 3'b100));            // -3 < 5
    emit(s_type(12'h118, 2, 0));
    emit(b_type(13'd8, 2, 1, 3'b100));
    emit(s_type(12'h11c, 2, 0));
    emit(b_type(13'd8, 3, 1, 3'b101));            // Equal counts as ge
    emit(s_type(12'h120, 3, 0));
    emit(b_type(13'd8, 1, 2, 3'b101));
    emit(s_type(12'h124, 1, 0));
    emit(i_type(12'd3, 0, 3'b000, 4, op_imm));
    emit(s_type(12'h130, 4, 0));
    emit(i_type(12'hfff, 4, 3'b000, 4, op_imm));
    emit(b_type(-13'sd8, 0, 4, 3'b001));          // Loop back three times
    finish_program();
  endtask

  task automatic jump_program();
    emit(j_type(21'd12, 1));
    emit(s_type(12'h1f0, 0, 0));
    emit(s_type(12'h1f4, 0, 0));
    emit(s_type(12'h108, 1, 0));
    emit(i_type(12'd41, 0, 3'b000, 2, op_imm));
    emit(i_type(12'd0, 2, 3'b000, 3, op_jalr));   // Lands on 40
    for (int i = 0; i < 4; i++) begin
      emit(s_type(12'h1e0 + 4 * i, 0, 0));
    end
    emit(s_type(12'h10c, 3, 0));
    emit(i_type(12'd49, 0, 3'b000, 6, op_imm));
    emit(i_type(12'd11, 6, 3'b000, 7, op_jalr));  // 60, bit 0 dropped
    emit(s_type(12'h1f8, 0, 0));
    emit(s_type(12'h1fc, 0, 0));
    emit(s_type(12'h110, 7, 0));
    finish_program();
  endtask

  function automatic word_t random_instr();
    logic [31:0] r;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [11:0] offs;
    r    = $random(seed);
    rd   = 5'd1 + {2'b00, r[2:0]};
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    f3   = r[11:9];
    offs = 12'h100 + {4'b0, r[21:16], 2'b00};
    case (r[14:12])
      3'd0, 3'd1: begin
        if (r[15] && (f3 == 3'b000 || f3 == 3'b101)) return r_type(7'h20, rs2, rs1, f3, rd);
        return r_type(7'h00, rs2, rs1, f3, rd);
      end
      3'd2, 3'd3: begin
        if (f3 == 3'b001) return i_type({7'h00, r[20:16]}, rs1, f3, rd, op_imm);
        if (f3 == 3'b101) return i_type({r[15] ? 7'h20 : 7'h00, r[20:16]}, rs1, f3, rd, op_imm);
        return i_type(r[27:16], rs1, f3, rd, op_imm);
      end
      3'd4:    return lui_instr(r[31:12], rd);
      3'd5:    return i_type(offs, 0, 3'b010, rd, op_load);
      default: return s_type(offs, rs2, 0);
    endcase
  endfunction

  task automatic random_program();
    logic [31:0] r;
    for (int i = 1; i < 9; i++) begin
      r = $random(seed);
      emit(i_type(r[11:0], 0, 3'b000, i, op_imm));
    end
    for (int i = 0; i < 40; i++) begin
      emit(random_instr());
    end
    for (int i = 1; i < 9; i++) begin
      emit(s_type(12'h300 + 4 * i, i, 0));
    end
    finish_program();
  endtask

  initial begin
    seed           = 32'h99c7129b;
    restart        = 1'b0;
    actual_count   = 0;
    store_done     = 1'b0;
    store_errors   = 0;
    count_errors   = 0;
    timeout_errors = 0;
    for (int i = 0; i < 1024; i++) begin
      prog[i] = nop_instr;
    end
    for (int i = 0; i < 256; i++) begin
      init_mem[i] = 32'ha5a5_0000 ^ (i * 32'h0001_0203);
      dmem[i]     = init_mem[i];
    end
    alu_program();
    run_program("ALU forwarding");
    load_program();
    run_program("load-use");
    branch_program();
    run_program("branches");
    jump_program();
    run_program("jumps");
    random_program();
    run_program("random");
    $display("Errors: store %0d, count %0d, timeout %0d",
             store_errors, count_errors, timeout_errors);
    if (store_errors + count_errors + timeout_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_hazard_unit.sv
rv_core.sv
tb_clock_gen.sv
rv_core_tb.sv
